//--- sources.f
+incdir+src
+incdir+test
src/cpuPkg.sv
src/aluUnit.sv
src/busRegisters.sv
src/fetchUnit.sv
src/memPort.sv
src/microSeq.sv
src/cpuTop.sv
test/cpuTb.sv

//--- Bender.yml
package:
  name: cpu16

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/cpuPkg.sv
      - src/aluUnit.sv
      - src/busRegisters.sv
      - src/fetchUnit.sv
      - src/memPort.sv
      - src/microSeq.sv
      - src/cpuTop.sv
  - target: test
    include_dirs:
      - src
      - test
    files:
      - test/cpuTb.sv

//--- test/cpuModel.svh
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

// one bus cycle that the model expects to see.
typedef struct packed {
    logic               fetch;
    logic               we;
    logic [`ADDR_W-1:0] adr;
    logic [`DATA_W-1:0] dat;
} cycleT;

logic [`DATA_W-1:0] modelMem [0:memWords-1];
cycleT              expTrace [$];
int                 modelInstrs;

// ==============================
// program generator
// ==============================

task automatic genProgram(output int len);
    int                 a;
    int                 i;
    logic [3:0]         op;
    logic [`ADDR_W-1:0] opnd;
    len = 8 + nextRand() % 57; // 8 to 64 instructions.
    for (a = 0; a < memWords; a++) begin
        if (a >= memWords / 2) mem[a] = nextRand(); // data lives in the upper half.
        else mem[a] = {`OP_HLT, a[`ADDR_W-1:0]};
    end
    for (i = 0; i < len - 1; i++) begin
        op = 4'(nextRand() % 13); // any opcode from LDX to JGT.
        case (op)
            `OP_LDX, `OP_LDY, `OP_STX: opnd = 12'h800 + 12'(nextRand() % 32);
            `OP_JMP, `OP_JC, `OP_JZ, `OP_JLT, `OP_JGT:
                opnd = 12'(i + 1 + nextRand() % (len - 1 - i)); // forward only.
            default: opnd = 12'(nextRand());
        endcase
        mem[i] = {op, opnd};
    end
    mem[len-1] = {`OP_HLT, 12'h000};
endtask

// ==============================
// instruction set model
// ==============================

task automatic runModel();
    logic [`DATA_W-1:0] xr;
    logic [`DATA_W-1:0] yr;
    logic [`DATA_W-1:0] res;
    logic [`DATA_W:0]   sum;
    logic [`ADDR_W-1:0] pcr;
    logic [`ADDR_W-1:0] opnd;
    logic [3:0]         op;
    logic               c, z, lt;
    logic               done, take, aluUsed;
    int                 a;
    for (a = 0; a < memWords; a++) modelMem[a] = mem[a];
    expTrace.delete();
    xr = '0;
    yr = '0;
    pcr = '0;
    {c, z, lt} = 3'b000;
    done = 1'b0;
    modelInstrs = 0;
    while (!done && modelInstrs < memWords) begin
        op   = modelMem[pcr][`DATA_W-1:`ADDR_W];
        opnd = modelMem[pcr][`ADDR_W-1:0];
        expTrace.push_back('{fetch: 1'b1, we: 1'b0, adr: pcr, dat: '0});
        pcr = pcr + 1'b1;
        modelInstrs++;
        take    = 1'b0;
        aluUsed = 1'b0;
        sum     = '0;
        res     = '0;
        case (op)
            `OP_LDX: begin
                expTrace.push_back('{fetch: 1'b0, we: 1'b0, adr: opnd, dat: '0});
                xr = modelMem[opnd];
            end
            `OP_LDY: begin
                expTrace.push_back('{fetch: 1'b0, we: 1'b0, adr: opnd, dat: '0});
                yr = modelMem[opnd];
            end
            `OP_LDI: xr = {4'h0, opnd};
            `OP_ADD: begin
                sum = {1'b0, xr} + {1'b0, yr};
                res = sum[`DATA_W-1:0];
                aluUsed = 1'b1;
            end
            `OP_SUB: begin
                sum = {1'b0, xr} + {1'b0, ~yr} + 17'd1; // x plus not y plus one.
                res = sum[`DATA_W-1:0];
                aluUsed = 1'b1;
            end
            `OP_AND, `OP_OR: begin
                sum = {1'b0, xr} + {1'b0, yr}; // the adder still adds, so c is its carry.
                res = (op == `OP_AND) ? (xr & yr) : (xr | yr);
                aluUsed = 1'b1;
            end
            `OP_STX: begin
                expTrace.push_back('{fetch: 1'b0, we: 1'b1, adr: opnd, dat: xr});
                modelMem[opnd] = xr;
            end
            `OP_JMP: take = 1'b1;
            `OP_JC:  take = c;
            `OP_JZ:  take = z;
            `OP_JLT: take = lt;
            `OP_JGT: take = !z && !lt;
            `OP_HLT: done = 1'b1;
            default: ;
        endcase
        if (aluUsed) begin
            c  = sum[`DATA_W];
            z  = (res == '0);
            lt = res[`DATA_W-1];
            xr = res;
        end
        if (take) pcr = opnd;
    end
endtask

`endif

//--- test/cpuTb.sv
`timescale 1ns/10ps
`include "cpu_consts.svh"

module cpuTb;
    import cpuPkg::*;

    localparam int programCount  = 20;
    localparam int maxInstr      = 64;
    localparam int timeoutCycles = programCount * maxInstr * 20 + 200;
    localparam int memWords      = 1 << `ADDR_W;

    logic               clk;
    logic               rstN;
    wbReqT              wbReq;
    wbRspT              wbRsp;
    logic               halted;
    logic [`DATA_W-1:0] mem [0:memWords-1];
    logic [31:0]        lcgState;
    wbReqT              held;
    logic               busy;
    int                 waitLeft;
    int                 traceIdx;
    int                 fetchCount, loadCount, storeCount;
    int                 checkCount, errorCount, cycleCount;

    cpuTop u_cpuTop (
        .clk(clk), .rstN(rstN), .wbReq(wbReq), .wbRsp(wbRsp), .halted(halted)
    );

    function automatic logic [15:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState[31:16]; // the low bits of an LCG repeat too quickly.
    endfunction

    `include "cpuModel.svh"

    // ==============================
    // clock and timeout
    // ==============================

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < timeoutCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: the run did not finish within %0d cycles", timeoutCycles);
        $display("FAIL: see errors above");
        $finish;
    end

    // ==============================
    // memory with wait states
    // ==============================

    task automatic checkCycle(input wbReqT req);
        cycleT want;
        checkCount++;
        assert (traceIdx < expTrace.size()) else begin
            $display("bus cycle at address %h came after the model's last one", req.adr);
            errorCount++;
        end
        if (traceIdx < expTrace.size()) begin
            want = expTrace[traceIdx];
            traceIdx++;
            checkCount++;
            if (want.fetch) begin
                fetchCount++;
                assert (!req.we && req.adr == want.adr) else begin
                    $display("Error at %0t: fetch we=%b adr=%h, model pc %h",
                             $time, req.we, req.adr, want.adr);
                    errorCount++;
                end
            end else if (want.we) begin
                storeCount++;
                assert (req.we && req.adr == want.adr && req.dat == want.dat) else begin
                    $display("Error at %0t: store we=%b %h <- %h, model %h <- %h",
                             $time, req.we, req.adr, req.dat, want.adr, want.dat);
                    errorCount++;
                end
            end else begin
                loadCount++;
                assert (!req.we && req.adr == want.adr) else begin
                    $display("Error at %0t: load we=%b adr=%h, model adr %h",
                             $time, req.we, req.adr, want.adr);
                    errorCount++;
                end
            end
        end
    endtask

    always @(posedge clk) begin
        #1;
        if (wbRsp.ack) begin
            wbRsp.ack = 1'b0; // the master took the ack at this edge.
            busy      = 1'b0;
        end else if (wbReq.cyc && wbReq.stb) begin
            if (!busy) begin
                busy     = 1'b1;
                held     = wbReq;
                waitLeft = nextRand() % 4;
                checkCycle(wbReq);
            end else begin
                checkCount++;
                assert (wbReq.we == held.we && wbReq.adr == held.adr
                        && wbReq.dat == held.dat) else begin
                    $display("Error at %0t: request moved during wait, %b %h %h to %b %h %h",
                             $time, held.we, held.adr, held.dat,
                             wbReq.we, wbReq.adr, wbReq.dat);
                    errorCount++;
                end
            end
            if (waitLeft == 0) begin
                if (wbReq.we) mem[wbReq.adr] = wbReq.dat;
                else wbRsp.dat = mem[wbReq.adr];
                wbRsp.ack = 1'b1;
            end else begin
                waitLeft--;
            end
        end
    end

    // ==============================
    // tests
    // ==============================

    task automatic checkIdle(input string stage);
        checkCount++;
        assert (!wbReq.cyc && !wbReq.stb && !halted) else begin
            $display("Error at %0t: cyc=%b stb=%b halted=%b %s",
                     $time, wbReq.cyc, wbReq.stb, halted, stage);
            errorCount++;
        end
    endtask

    task automatic compareMemory();
        int a;
        for (a = 0; a < memWords; a++) begin
            checkCount++;
            assert (mem[a] === modelMem[a]) else begin
                $display("Error at %0t: mem[%h] is %h, model has %h",
                         $time, a[`ADDR_W-1:0], mem[a], modelMem[a]);
                errorCount++;
            end
        end
    endtask

    task automatic runProgram(input int prog);
        int len;
        int errorsBefore;
        errorsBefore = errorCount;
        rstN = 1'b0;
        genProgram(len);
        runModel();
        traceIdx   = 0;
        fetchCount = 0;
        loadCount  = 0;
        storeCount = 0;
        repeat (8) begin
            @(posedge clk);
            #1;
            checkIdle("while reset is held");
        end
        rstN = 1'b1;
        #1;
        checkIdle("in the first cycle after reset");
        while (!halted) begin
            @(posedge clk);
            #1;
        end
        repeat (20) begin
            @(posedge clk);
            #1;
            checkCount++;
            assert (!wbReq.cyc && halted) else begin
                $display("program %0d: a bus cycle started or halted fell after HLT", prog);
                errorCount++;
            end
        end
        checkCount++;
        assert (traceIdx == expTrace.size()) else begin
            $display("program %0d: only %0d of %0d expected bus cycles were seen",
                     prog, traceIdx, expTrace.size());
            errorCount++;
        end
        compareMemory();
        $display("test %0d: %0d instructions, %0d fetches, %0d loads, %0d stores, %0d errors",
                 prog, modelInstrs, fetchCount, loadCount, storeCount,
                 errorCount - errorsBefore);
    endtask

    initial begin
        int p;
        $timeformat(-9, 0, " ns", 0);
        lcgState   = 32'd74440;
        rstN       = 1'b0;
        wbRsp      = '0;
        held       = '0;
        busy       = 1'b0;
        waitLeft   = 0;
        traceIdx   = 0;
        checkCount = 0;
        errorCount = 0;
        for (p = 0; p < programCount; p++) begin
            runProgram(p);
        end
        $display("%0d tests, %0d checks, %0d errors", programCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- src/cpuTop.sv
`timescale 1ns/10ps
`include "cpu_consts.svh"

module cpuTop (
    input  logic          clk,
    input  logic          rstN,
    output cpuPkg::wbReqT wbReq,
    input  cpuPkg::wbRspT wbRsp,
    output logic          halted
);
    import cpuPkg::*;

    ctrlWordT           ctrl;
    instrT              instr;
    flagsT              flags;
    logic               memDone;
    logic [`DATA_W-1:0] memData;
    logic [`DATA_W-1:0] bus;
    logic [`DATA_W-1:0] aluRes;
    logic [`DATA_W-1:0] x;
    logic [`DATA_W-1:0] y;
    logic [`ADDR_W-1:0] addr;
    logic [`ADDR_W-1:0] pc;

    // ==============================
    // control
    // ==============================

    microSeq u_microSeq (
        .clk(clk), .rstN(rstN), .instr(instr), .flags(flags),
        .memDone(memDone), .ctrl(ctrl), .halted(halted)
    );

    // ==============================
    // datapath
    // ==============================

    fetchUnit u_fetchUnit (
        .clk(clk), .rstN(rstN), .ctrl(ctrl), .bus(bus), .pc(pc), .instr(instr)
    );

    busRegisters u_busRegisters (
        .clk(clk), .rstN(rstN), .ctrl(ctrl), .aluRes(aluRes), .memData(memData),
        .operand(instr.operand), .pc(pc), .bus(bus), .x(x), .y(y), .addr(addr)
    );

    aluUnit u_aluUnit (
        .clk(clk), .rstN(rstN), .ctrl(ctrl), .x(x), .y(y),
        .aluRes(aluRes), .flags(flags)
    );

    memPort u_memPort (
        .clk(clk), .rstN(rstN), .ctrl(ctrl), .pc(pc), .addr(addr), .x(x),
        .memData(memData), .memDone(memDone), .wbReq(wbReq), .wbRsp(wbRsp)
    );

endmodule

//--- src/microSeq.sv
`timescale 1ns/10ps
`include "cpu_consts.svh"

module microSeq (
    input  logic             clk,
    input  logic             rstN,
    input  cpuPkg::instrT    instr,
    input  cpuPkg::flagsT    flags,
    input  logic             memDone,
    output cpuPkg::ctrlWordT ctrl,
    output logic             halted
);
    import cpuPkg::*;

    localparam int TW = $clog2(`T_MAX);

    logic [TW-1:0] tState;
    ctrlWordT      decoded;
    logic          jumpOk;
    logic          stall;

    // ==============================
    // decode
    // ==============================

    always_comb begin
        decoded = '0;
        case (tState)
            0: begin // fetch.
                decoded.busSrc  = srcMem;
                decoded.memRead = 1'b1;
                decoded.irLoad  = 1'b1;
                decoded.pcInc   = 1'b1;
            end
            1: begin
                case (instr.op)
                    opLdx, opLdy, opStx: begin
                        decoded.busSrc   = srcOperand;
                        decoded.addrLoad = 1'b1;
                    end
                    opLdi: begin
                        decoded.busSrc   = srcOperand;
                        decoded.xLoad    = 1'b1;
                        decoded.endInstr = 1'b1;
                    end
                    opAdd, opSub, opAnd, opOr: begin
                        decoded.busSrc    = srcAlu;
                        decoded.xLoad     = 1'b1;
                        decoded.flagsLoad = 1'b1;
                        decoded.aluOp     = aluOpT'(instr.op - opAdd); // same order as aluOpT.
                        decoded.endInstr  = 1'b1;
                    end
                    opJmp, opJc, opJz, opJlt, opJgt: begin
                        decoded.busSrc   = srcOperand;
                        decoded.pcLoad   = 1'b1;
                        decoded.endInstr = 1'b1;
                    end
                    opHlt: begin
                        decoded.halt     = 1'b1;
                        decoded.endInstr = 1'b1;
                    end
                    default: decoded.endInstr = 1'b1; // unused opcodes act as no-ops.
                endcase
            end
            2: begin // data bus cycle.
                decoded.addrSel  = 1'b1;
                decoded.endInstr = 1'b1;
                case (instr.op)
                    opLdx: begin
                        decoded.busSrc  = srcMem;
                        decoded.memRead = 1'b1;
                        decoded.xLoad   = 1'b1;
                    end
                    opLdy: begin
                        decoded.busSrc  = srcMem;
                        decoded.memRead = 1'b1;
                        decoded.yLoad   = 1'b1;
                    end
                    opStx:   decoded.memWrite = 1'b1;
                    default: decoded.addrSel  = 1'b0;
                endcase
            end
            default: decoded.endInstr = 1'b1;
        endcase
    end

    always_comb begin
        case (instr.op)
            opJc:    jumpOk = flags.c;
            opJz:    jumpOk = flags.z;
            opJlt:   jumpOk = flags.lt;
            opJgt:   jumpOk = ~flags.z & ~flags.lt;
            default: jumpOk = 1'b1;
        endcase
    end

    // ==============================
    // gating
    // ==============================

    assign stall = (decoded.memRead | decoded.memWrite) & ~memDone;

    always_comb begin
        ctrl = decoded;
        if (halted) begin
            ctrl = '0;
        end else begin
            if (stall) begin // loads wait for the data.
                ctrl.xLoad    = 1'b0;
                ctrl.yLoad    = 1'b0;
                ctrl.irLoad   = 1'b0;
                ctrl.pcInc    = 1'b0;
                ctrl.endInstr = 1'b0;
            end
            if (!jumpOk) ctrl.pcLoad = 1'b0;
        end
    end

    // ==============================
    // T-state and halt
    // ==============================

    always_ff @(posedge clk) begin
        if (!rstN) begin
            tState <= '0;
            halted <= 1'b0;
        end else begin
            if (ctrl.halt) halted <= 1'b1; // held until reset.
            if (ctrl.endInstr) begin
                tState <= '0;
            end else if (!halted && !stall) begin
                tState <= tState + 1'b1;
            end
        end
    end

endmodule

//--- src/memPort.sv
`timescale 1ns/10ps
`include "cpu_consts.svh"

module memPort (
    input  logic               clk,
    input  logic               rstN,
    input  cpuPkg::ctrlWordT   ctrl,
    input  logic [`ADDR_W-1:0] pc,
    input  logic [`ADDR_W-1:0] addr,
    input  logic [`DATA_W-1:0] x,
    output logic [`DATA_W-1:0] memData,
    output logic               memDone,
    output cpuPkg::wbReqT      wbReq,
    input  cpuPkg::wbRspT      wbRsp
);
    logic               cycOn;
    logic               weQ;
    logic [`ADDR_W-1:0] adrQ;
    logic [`DATA_W-1:0] datQ;
    logic               request;
    logic               start;

    assign request = ctrl.memRead | ctrl.memWrite;

    // the sequencer still shows the request during memDone, so that cycle must not restart.
    assign start = request & ~cycOn & ~memDone;

    // ==============================
    // cycle control
    // ==============================

    always_ff @(posedge clk) begin
        if (!rstN) begin
            cycOn   <= 1'b0;
            weQ     <= 1'b0;
            memDone <= 1'b0;
        end else begin
            memDone <= 1'b0;
            if (cycOn) begin
                if (wbRsp.ack) begin
                    cycOn   <= 1'b0; // cyc and stb drop the cycle after ack.
                    memDone <= 1'b1;
                end
            end else if (start) begin
                cycOn <= 1'b1;
                weQ   <= ctrl.memWrite;
            end
        end
    end

    // address and write data held stable for the whole cycle.
    always_ff @(posedge clk) begin
        if (start) begin
            adrQ <= ctrl.addrSel ? addr : pc;
            datQ <= x;
        end
        if (cycOn && wbRsp.ack) begin
            memData <= wbRsp.dat;
        end
    end

    assign wbReq = '{
        cyc: cycOn,
        stb: cycOn,
        we:  weQ,
        adr: adrQ,
        dat: datQ
    };

endmodule

//--- src/fetchUnit.sv
`timescale 1ns/10ps
`include "cpu_consts.svh"

module fetchUnit (
    input  logic               clk,
    input  logic               rstN,
    input  cpuPkg::ctrlWordT   ctrl,
    input  logic [`DATA_W-1:0] bus,
    output logic [`ADDR_W-1:0] pc,
    output cpuPkg::instrT      instr
);
    import cpuPkg::*;

    logic [`ADDR_W-1:0] pcNext;

    // ==============================
    // program counter
    // ==============================

    always_comb begin
        pcNext = pc;
        if (ctrl.pcLoad) begin
            pcNext = bus[`ADDR_W-1:0]; // taken jump.
        end else if (ctrl.pcInc) begin
            pcNext = pc + 1'b1; // wraps at the top of memory.
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    // ==============================
    // instruction register
    // ==============================

    always_ff @(posedge clk) begin
        if (!rstN) begin
            instr <= '0;
        end else if (ctrl.irLoad) begin
            instr <= instrT'(bus);
        end
    end

endmodule

//--- src/busRegisters.sv
`timescale 1ns/10ps
`include "cpu_consts.svh"

module busRegisters (
    input  logic               clk,
    input  logic               rstN,
    input  cpuPkg::ctrlWordT   ctrl,
    input  logic [`DATA_W-1:0] aluRes,
    input  logic [`DATA_W-1:0] memData,
    input  logic [`ADDR_W-1:0] operand,
    input  logic [`ADDR_W-1:0] pc,
    output logic [`DATA_W-1:0] bus,
    output logic [`DATA_W-1:0] x,
    output logic [`DATA_W-1:0] y,
    output logic [`ADDR_W-1:0] addr
);
    import cpuPkg::*;

    always_comb begin
        case (ctrl.busSrc)
            srcAlu:     bus = aluRes;
            srcMem:     bus = memData;
            srcOperand: bus = {{(`DATA_W-`ADDR_W){1'b0}}, operand}; // zero-extended.
            srcPc:      bus = {{(`DATA_W-`ADDR_W){1'b0}}, pc};
            default:    bus = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            x    <= '0;
            y    <= '0;
            addr <= '0;
        end else begin
            if (ctrl.xLoad)    x    <= bus;
            if (ctrl.yLoad)    y    <= bus;
            if (ctrl.addrLoad) addr <= bus[`ADDR_W-1:0]; // upper bits are dropped.
        end
    end

endmodule

//--- src/aluUnit.sv
`timescale 1ns/10ps
`include "cpu_consts.svh"

module aluUnit (
    input  logic               clk,
    input  logic               rstN,
    input  cpuPkg::ctrlWordT   ctrl,
    input  logic [`DATA_W-1:0] x,
    input  logic [`DATA_W-1:0] y,
    output logic [`DATA_W-1:0] aluRes,
    output cpuPkg::flagsT      flags
);
    import cpuPkg::*;

    logic               subOp;
    logic [`DATA_W-1:0] yOperand;
    logic [`DATA_W:0]   sum;

    // ==============================
    // adder and logic ops
    // ==============================

    assign subOp    = (ctrl.aluOp == aluSub);
    assign yOperand = subOp ? ~y : y; // x - y is x + ~y + 1.

    // the adder also runs for and/or, so its carry is what c records there.
    assign sum = {1'b0, x} + {1'b0, yOperand} + {{`DATA_W{1'b0}}, subOp};

    always_comb begin
        case (ctrl.aluOp)
            aluAdd:  aluRes = sum[`DATA_W-1:0];
            aluSub:  aluRes = sum[`DATA_W-1:0];
            aluAnd:  aluRes = x & y;
            aluOr:   aluRes = x | y;
            default: aluRes = '0;
        endcase
    end

    // ==============================
    // flag register
    // ==============================

    always_ff @(posedge clk) begin
        if (!rstN) begin
            flags <= '0;
        end else if (ctrl.flagsLoad) begin
            flags.c  <= sum[`DATA_W];
            flags.z  <= (aluRes == '0);
            flags.lt <= aluRes[`DATA_W-1]; // sign bit of the result.
        end
    end

endmodule

//--- src/cpuPkg.sv
`include "cpu_consts.svh"

package cpuPkg;

    typedef enum logic [3:0] {
        opLdx = `OP_LDX,
        opLdy = `OP_LDY,
        opLdi = `OP_LDI,
        opAdd = `OP_ADD,
        opSub = `OP_SUB,
        opAnd = `OP_AND,
        opOr  = `OP_OR,
        opStx = `OP_STX,
        opJmp = `OP_JMP,
        opJc  = `OP_JC,
        opJz  = `OP_JZ,
        opJlt = `OP_JLT,
        opJgt = `OP_JGT,
        opHlt = `OP_HLT
    } opcodeT;

    typedef struct packed {
        opcodeT             op;
        logic [`ADDR_W-1:0] operand; // address or immediate.
    } instrT;

    typedef enum logic [2:0] {
        srcNone,
        srcAlu,
        srcMem,
        srcOperand,
        srcPc
    } busSrcT;

    typedef enum logic [1:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr
    } aluOpT;

    typedef struct packed {
        logic c;
        logic z;
        logic lt;
    } flagsT;

    // ==============================
    // microinstruction
    // ==============================

    typedef struct packed {
        busSrcT busSrc;
        logic   xLoad;
        logic   yLoad;
        logic   addrLoad;
        logic   irLoad;
        logic   flagsLoad;
        logic   pcInc;
        logic   pcLoad;
        logic   memRead;
        logic   memWrite;
        logic   addrSel;  // 0 takes the pc, 1 the address register.
        aluOpT  aluOp;
        logic   endInstr;
        logic   halt;
    } ctrlWordT;

    typedef struct packed {
        logic               cyc;
        logic               stb;
        logic               we;
        logic [`ADDR_W-1:0] adr;
        logic [`DATA_W-1:0] dat;
    } wbReqT;

    typedef struct packed {
        logic               ack;
        logic [`DATA_W-1:0] dat;
    } wbRspT;

endpackage

//--- src/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// ==============================
// widths
// ==============================

`define DATA_W 16
`define ADDR_W 12

// ==============================
// opcodes
// ==============================

`define OP_LDX 4'h0
`define OP_LDY 4'h1
`define OP_LDI 4'h2
`define OP_ADD 4'h3
`define OP_SUB 4'h4
`define OP_AND 4'h5
`define OP_OR  4'h6
`define OP_STX 4'h7
`define OP_JMP 4'h8
`define OP_JC  4'h9
`define OP_JZ  4'hA
`define OP_JLT 4'hB
`define OP_JGT 4'hC
`define OP_HLT 4'hD

`define T_MAX 4 // number of microsteps in one instruction.

`endif
